// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_stepper
FILELIST = all.f

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: all.f
source/stepper_pkg.sv
source/step_rate_gen.sv
source/phase_sequencer.sv
source/coil_driver.sv
source/stepper_top.sv
testbench/tb_stepper.sv

// File: source/coil_driver.sv
`timescale 1ns/1ps

module coil_driver #(
  parameter int IDLE_CYCLES = 64
) (
  input  logic       step,
  input  logic       rst_n,
  input  logic [3:0] pattern,
  input  logic       pattern_valid,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2
);

  localparam int IDLE_W = $clog2(IDLE_CYCLES + 1);

  logic [1:0]        a_q;       // bridge inputs of coil a, a1 in bit 1.
  logic [1:0]        b_q;       // bridge inputs of coil b, b1 in bit 1.
  logic [1:0]        a_pend;    // value coil a takes after its off cycle.
  logic [1:0]        b_pend;
  logic              a_wait;
  logic              b_wait;
  logic [IDLE_W-1:0] idle_cnt;  // cycles since the last new pattern.
  logic              release_now;

  // True when a pair would swap polarity without passing through off.
  function automatic logic reverses(input logic [1:0] cur, input logic [1:0] req);
    reverses = (cur == 2'b10 && req == 2'b01) || (cur == 2'b01 && req == 2'b10);
  endfunction

  assign release_now = (idle_cnt == IDLE_W'(IDLE_CYCLES - 1));

  always_ff @(posedge step) begin
    if (!rst_n) begin
      a_q      <= 2'b00;
      b_q      <= 2'b00;
      a_wait   <= 1'b0;
      b_wait   <= 1'b0;
      idle_cnt <= IDLE_W'(IDLE_CYCLES); // start released.
    end else if (pattern_valid) begin
      idle_cnt <= '0;
      a_wait   <= reverses(a_q, pattern[3:2]);
      b_wait   <= reverses(b_q, pattern[1:0]);
      a_q      <= reverses(a_q, pattern[3:2]) ? 2'b00 : pattern[3:2];
      b_q      <= reverses(b_q, pattern[1:0]) ? 2'b00 : pattern[1:0];
    end else if (release_now) begin
      a_q      <= 2'b00; // no step for too long, let the coils go.
      b_q      <= 2'b00;
      a_wait   <= 1'b0;
      b_wait   <= 1'b0;
      idle_cnt <= IDLE_W'(IDLE_CYCLES);
    end else begin
      if (a_wait) begin
        a_q    <= a_pend;
        a_wait <= 1'b0;
      end
      if (b_wait) begin
        b_q    <= b_pend;
        b_wait <= 1'b0;
      end
      if (idle_cnt != IDLE_W'(IDLE_CYCLES)) begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge step) begin
    if (pattern_valid) begin
      a_pend <= pattern[3:2];
      b_pend <= pattern[1:0];
    end
  end

  assign phase_a1 = a_q[1];
  assign phase_a2 = a_q[0];
  assign phase_b1 = b_q[1];
  assign phase_b2 = b_q[0];

endmodule

// File: source/phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer (
  input  logic                                   step,
  input  logic                                   rst_n,
  input  logic                                   advance,
  input  logic                                   dir,
  input  stepper_pkg::step_mode_e                mode,
  output logic [3:0]                             pattern,
  output logic                                   pattern_valid,
  output logic signed [stepper_pkg::POS_W-1:0]   position
);

  import stepper_pkg::*;

  logic [2:0] index;      // phase index into the eight-entry half-step table.
  logic [2:0] index_next;
  logic [1:0] step_size;  // half steps taken on this advance.

  // Full mode moves two half steps, unless the index sits on an odd entry.
  // Then a single half step brings it back onto the full-step grid.
  always_comb begin
    if (mode == MODE_HALF || index[0]) begin
      step_size = 2'd1;
    end else begin
      step_size = 2'd2;
    end
  end

  always_comb begin
    if (dir) begin
      index_next = index + {1'b0, step_size}; // forward wraps from 7 to 0.
    end else begin
      index_next = index - {1'b0, step_size}; // reverse wraps from 0 to 7.
    end
  end

  // coil table in the order a1 a2 b1 b2, even entries are the full steps.
  always_comb begin
    case (index)
      3'd0:    pattern = 4'b1010;
      3'd1:    pattern = 4'b0010;
      3'd2:    pattern = 4'b0110;
      3'd3:    pattern = 4'b0100;
      3'd4:    pattern = 4'b0101;
      3'd5:    pattern = 4'b0001;
      3'd6:    pattern = 4'b1001;
      default: pattern = 4'b1000;
    endcase
  end

  always_ff @(posedge step) begin
    if (!rst_n) begin
      index         <= 3'd0;
      pattern_valid <= 1'b0;
      position      <= '0;
    end else begin
      pattern_valid <= advance; // marks the cycle in which the new pattern shows.
      if (advance) begin
        index <= index_next;
        if (dir) begin
          position <= position + POS_W'(step_size);
        end else begin
          position <= position - POS_W'(step_size);
        end
      end
    end
  end

endmodule

// File: source/step_rate_gen.sv
`timescale 1ns/1ps

module step_rate_gen #(
  parameter int PERIOD_W = 8,
  parameter int COUNT_W  = 8
) (
  input  logic                step,
  input  logic                rst_n,
  input  logic                start,
  input  logic [COUNT_W-1:0]  step_count,
  input  logic [PERIOD_W-1:0] period,
  output logic                advance,
  output logic                busy
);

  import stepper_pkg::*;

  rate_state_e         state;
  logic [PERIOD_W-1:0] period_cnt; // cycles left until the next advance.
  logic [PERIOD_W-1:0] period_q;   // period of the running move.
  logic [COUNT_W-1:0]  remaining;  // advances still to be issued.
  logic                last_step;

  // An advance fires when the period counter has run out and steps remain.
  assign advance   = (state == RATE_RUN) && (remaining != '0) && (period_cnt == '0);
  assign last_step = (remaining == COUNT_W'(1));
  assign busy      = (state == RATE_RUN); // state is a register, so busy is too.

  always_ff @(posedge step) begin
    if (!rst_n) begin
      state      <= RATE_IDLE;
      period_cnt <= '0;
      remaining  <= '0;
    end else begin
      case (state)
        RATE_IDLE: begin
          if (start) begin
            state      <= RATE_RUN;
            period_cnt <= period - 1'b1; // first advance lands period cycles after start.
            remaining  <= step_count;
          end
        end
        RATE_RUN: begin
          if (remaining == '0) begin
            state <= RATE_IDLE; // a zero-length move ends right away.
          end else if (period_cnt == '0) begin
            period_cnt <= period_q - 1'b1; // reload for the next step.
            remaining  <= remaining - 1'b1;
            if (last_step) begin
              state <= RATE_IDLE;
            end
          end else begin
            period_cnt <= period_cnt - 1'b1;
          end
        end
        default: begin
          state <= RATE_IDLE;
        end
      endcase
    end
  end

  // Period is captured with the move so the host may change it afterwards.
  always_ff @(posedge step) begin
    if (state == RATE_IDLE && start) begin
      period_q <= period;
    end
  end

endmodule

// File: source/stepper_pkg.sv
package stepper_pkg;

  // width of the signed position counter, in half steps.
  localparam int POS_W = 16;

  // step mode of a move.
  typedef enum logic {
    MODE_FULL = 1'b0, // two half steps per advance, both coils energized.
    MODE_HALF = 1'b1  // one half step per advance, alternating one and two coils.
  } step_mode_e;

  // state of the step rate generator.
  typedef enum logic {
    RATE_IDLE = 1'b0, // waiting for a start strobe.
    RATE_RUN  = 1'b1  // a move is in progress.
  } rate_state_e;

endpackage

// File: source/stepper_top.sv
`timescale 1ns/1ps

module stepper_top #(
  parameter int PERIOD_W    = 8,
  parameter int COUNT_W     = 8,
  parameter int IDLE_CYCLES = 64
) (
  input  logic                                 step,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  logic [COUNT_W-1:0]                   step_count,
  input  logic [PERIOD_W-1:0]                  period,
  input  logic                                 dir,
  input  stepper_pkg::step_mode_e              mode,
  output logic                                 busy,
  output logic signed [stepper_pkg::POS_W-1:0] position,
  output logic                                 phase_a1,
  output logic                                 phase_a2,
  output logic                                 phase_b1,
  output logic                                 phase_b2
);

  logic       advance;       // one strobe per step from the rate generator.
  logic [3:0] pattern;       // requested coil pattern, a1 a2 b1 b2.
  logic       pattern_valid;

  step_rate_gen #(
    .PERIOD_W (PERIOD_W),
    .COUNT_W  (COUNT_W)
  ) u_rate (
    .step       (step),
    .rst_n      (rst_n),
    .start      (start),
    .step_count (step_count),
    .period     (period),
    .advance    (advance),
    .busy       (busy)
  );

  // dir and mode come straight from the host, who holds them for the move.
  phase_sequencer u_seq (
    .step          (step),
    .rst_n         (rst_n),
    .advance       (advance),
    .dir           (dir),
    .mode          (mode),
    .pattern       (pattern),
    .pattern_valid (pattern_valid),
    .position      (position)
  );

  coil_driver #(
    .IDLE_CYCLES (IDLE_CYCLES)
  ) u_coil (
    .step          (step),
    .rst_n         (rst_n),
    .pattern       (pattern),
    .pattern_valid (pattern_valid),
    .phase_a1      (phase_a1),
    .phase_a2      (phase_a2),
    .phase_b1      (phase_b1),
    .phase_b2      (phase_b2)
  );

endmodule

// File: testbench/tb_stepper.sv
`timescale 1ns/1ps

module tb_stepper;

  import stepper_pkg::*;

  localparam int PERIOD_W    = 8;
  localparam int COUNT_W     = 8;
  localparam int IDLE_CYCLES = 40;
  localparam int N_MOVES     = 12;

  logic                    step;
  logic                    rst_n;
  logic                    start;
  logic [COUNT_W-1:0]      step_count;
  logic [PERIOD_W-1:0]     period;
  logic                    dir;
  step_mode_e              mode;
  logic                    busy;
  logic signed [POS_W-1:0] position;
  logic                    phase_a1;
  logic                    phase_a2;
  logic                    phase_b1;
  logic                    phase_b2;

  logic [1:0] a_pair;
  logic [1:0] b_pair;
  logic [3:0] coil_now;

  // expected coil patterns for index 0 to 7, a1 a2 b1 b2.
  logic [3:0] coil_table [8] = '{4'b1010, 4'b0010, 4'b0110, 4'b0100,
                                 4'b0101, 4'b0001, 4'b1001, 4'b1000};

  logic [2:0]              model_idx;
  logic signed [POS_W-1:0] model_pos;
  logic                    coils_on; // the model expects energized coils.
  int                      cyc;
  int                      limit;
  logic [31:0]             rng_state;

  int         mv_count  [N_MOVES];
  int         mv_period [N_MOVES];
  logic       mv_dir    [N_MOVES];
  step_mode_e mv_mode   [N_MOVES];
  logic       mv_poke   [N_MOVES]; // a second start is sent while the move runs.
  logic       mv_idle   [N_MOVES]; // the coils are left to release after the move.

  assign a_pair   = {phase_a1, phase_a2};
  assign b_pair   = {phase_b1, phase_b2};
  assign coil_now = {a_pair, b_pair};

  stepper_top #(
    .PERIOD_W    (PERIOD_W),
    .COUNT_W     (COUNT_W),
    .IDLE_CYCLES (IDLE_CYCLES)
  ) DUT (
    .step       (step),
    .rst_n      (rst_n),
    .start      (start),
    .step_count (step_count),
    .period     (period),
    .dir        (dir),
    .mode       (mode),
    .busy       (busy),
    .position   (position),
    .phase_a1   (phase_a1),
    .phase_a2   (phase_a2),
    .phase_b1   (phase_b1),
    .phase_b2   (phase_b2)
  );

  always begin
    #50 step = ~step;
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic expect_equal(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
    assert (expected === actual)
      else stop_on_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge step) begin
    cyc <= cyc + 1;
    if (cyc > limit) begin
      stop_on_failure($sformatf("timeout, the run did not finish within %0d cycles", limit));
    end
  end

  // A bridge leg pair must never short, and must pass through off when it reverses.
  assert property (@(posedge step) disable iff (!rst_n) a_pair != 2'b11)
    else stop_on_failure($sformatf("ERROR phase_a1/phase_a2 both high, value %h", a_pair));
  assert property (@(posedge step) disable iff (!rst_n) b_pair != 2'b11)
    else stop_on_failure($sformatf("ERROR phase_b1/phase_b2 both high, value %h", b_pair));
  assert property (@(posedge step) disable iff (!rst_n) (a_pair ^ $past(a_pair)) != 2'b11)
    else stop_on_failure($sformatf("ERROR phase_a1/phase_a2 reversed to %h with no off cycle",
                                   a_pair));
  assert property (@(posedge step) disable iff (!rst_n) (b_pair ^ $past(b_pair)) != 2'b11)
    else stop_on_failure($sformatf("ERROR phase_b1/phase_b2 reversed to %h with no off cycle",
                                   b_pair));

  // Full steps from an odd index take one half step back onto the even grid.
  task automatic advance_model(input logic d, input step_mode_e m);
    logic [2:0] size;
    size = (m == MODE_HALF || model_idx[0]) ? 3'd1 : 3'd2;
    if (d) begin
      model_idx = model_idx + size;
      model_pos = model_pos + POS_W'(size);
    end else begin
      model_idx = model_idx - size;
      model_pos = model_pos - POS_W'(size);
    end
  endtask

  task automatic run_move(input int count, input int per, input logic d,
                          input step_mode_e m, input logic poke);
    int         t0;
    int         last_t;
    int         k;
    logic [3:0] coil_idle;
    @(posedge step);
    start      <= 1'b1;
    step_count <= COUNT_W'(count);
    period     <= PERIOD_W'(per);
    dir        <= d;
    mode       <= m;
    @(posedge step);
    start <= 1'b0;
    t0 = cyc;
    expect_equal("busy", 16'd0, {15'd0, busy}); // still low in the start cycle.
    @(posedge step);
    expect_equal("busy", 16'd1, {15'd0, busy});
    last_t = t0 + 1; // position shows each step one cycle after its advance.
    for (k = 0; k < count; k++) begin
      while (position == model_pos) begin
        @(posedge step);
      end
      expect_equal("step spacing", 16'(per), 16'(cyc - last_t));
      last_t = cyc;
      expect_equal("busy", (k == count - 1) ? 16'd0 : 16'd1, {15'd0, busy});
      advance_model(d, m);
      expect_equal("position", model_pos, position);
      @(posedge step);
      @(posedge step);
      expect_equal("coils", {12'd0, coil_table[model_idx]}, {12'd0, coil_now});
      coils_on = 1'b1;
      if (poke && k == 0 && count > 1) begin // the move must still be running.
        start      <= 1'b1;
        step_count <= COUNT_W'(count + 5);
        @(posedge step);
        start <= 1'b0;
      end
    end
    while (busy) begin
      @(posedge step);
    end
    expect_equal("position", model_pos, position);
    if (count == 0) begin
      coil_idle = coils_on ? coil_table[model_idx] : 4'b0000;
      expect_equal("coils", {12'd0, coil_idle}, {12'd0, coil_now});
    end
  endtask

  task automatic wait_for_release();
    int n;
    for (n = 0; n < IDLE_CYCLES + 2; n++) begin
      @(posedge step);
    end
    expect_equal("coils", 16'd0, {12'd0, coil_now});
    coils_on = 1'b0;
  endtask

  initial begin
    int i;
    int total;
    step       = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    step_count = '0;
    period     = PERIOD_W'(1);
    dir        = 1'b1;
    mode       = MODE_FULL;
    cyc        = 0;
    model_idx  = 3'd0;
    model_pos  = '0;
    coils_on   = 1'b0;
    rng_state  = 32'h17d7;

    // directed moves first, then random ones.
    mv_count  = '{6, 5, 3, 0, 4, 0, 0, 0, 0, 0, 0, 0};
    mv_period = '{5, 4, 6, 5, 7, 0, 0, 0, 0, 0, 0, 0};
    mv_dir    = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    mv_mode   = '{MODE_FULL, MODE_HALF, MODE_FULL, MODE_FULL, MODE_FULL, MODE_FULL,
                  MODE_FULL, MODE_FULL, MODE_FULL, MODE_FULL, MODE_FULL, MODE_FULL};
    mv_poke   = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    mv_idle   = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    for (i = 5; i < N_MOVES; i++) begin
      rng_state    = next_random(rng_state);
      mv_count[i]  = 1 + int'(rng_state[19:16]) % 12;
      mv_period[i] = 4 + int'(rng_state[26:24]); // long enough for the coils to settle.
      mv_dir[i]    = rng_state[28];
      mv_mode[i]   = step_mode_e'(rng_state[29]);
      mv_idle[i]   = rng_state[30];
      mv_poke[i]   = rng_state[31];
    end

    total = 200;
    for (i = 0; i < N_MOVES; i++) begin
      total = total + mv_count[i] * (mv_period[i] + 1) + 200;
    end
    limit = total;

    repeat (5) @(posedge step);
    rst_n <= 1'b1;
    @(posedge step);
    @(posedge step);
    expect_equal("coils", 16'd0, {12'd0, coil_now});
    expect_equal("position", 16'd0, position);
    expect_equal("busy", 16'd0, {15'd0, busy});

    for (i = 0; i < N_MOVES; i++) begin
      run_move(mv_count[i], mv_period[i], mv_dir[i], mv_mode[i], mv_poke[i]);
      if (i == 0) begin
        expect_equal("position", 16'(2 * mv_count[0]), position);
      end
      if (mv_idle[i]) begin
        wait_for_release();
      end
    end

    $display("Testbench passed");
    $finish;
  end

endmodule
